// File: bench/i2cSlaveModel.sv
// Behavioral I2C slave answering several read addresses
// Protocol checks on START, STOP, address order and host ACK/NACK
module i2cSlaveModel (
	input  logic        scl,
	input  logic        sda,
	input  logic        active,		// Ignore the bus during reset
	input  logic [6:0]  nackAdrs,	// Address left unanswered
	input  logic [15:0] keyData1,	// First byte in the upper half
	input  logic [15:0] keyData2,
	input  logic [15:0] gyroData,
	output logic        slavePull,	// 1 pulls SDA low
	output int          startCount,
	output logic        protoErr
);

	typedef enum {sIdle, sAddr, sAckOut, sAckHold, sData, sByteEnd, sHostAck, sNextByte,
		sWaitStop} modelState;

	modelState   st;
	logic [7:0]  shiftIn;
	logic [7:0]  txByte;
	logic [15:0] word;
	logic [6:0]  curAdrs;
	logic [7:0]  adrsOrder [0:2];	// Address byte with read bit
	int          bitCnt;
	int          byteIdx;
	int          orderIdx;

	initial
	begin
		st           = sIdle;
		slavePull    = 1'b0;
		startCount   = 0;
		protoErr     = 1'b0;
		orderIdx     = 0;
		adrsOrder[0] = 8'h05;
		adrsOrder[1] = 8'h07;
		adrsOrder[2] = 8'h09;
	end

	function automatic logic [15:0] pickData(input logic [6:0] adrs);
		case (adrs)
			7'h02:   return keyData1;
			7'h03:   return keyData2;
			default: return gyroData;
		endcase
	endfunction

	task automatic reportValue(input string name, input int expVal, input int actVal);
		$display("[ERROR] %0t %s expected %0h actual %0h", $time, name, expVal, actVal);
		protoErr = 1'b1;
	endtask

	task automatic reportText(input string msg);
		$display("[ERROR] %0t %s", $time, msg);
		protoErr = 1'b1;
	endtask

	//----------------------------------------------------------------------
	// START and STOP, the only SDA edges allowed with SCL high
	//----------------------------------------------------------------------
	always @(negedge sda)
	begin
		if (active && scl === 1'b1)
		begin
			assert (st == sIdle) else reportText("START or SDA change inside a transfer");
			st     = sAddr;
			bitCnt = 0;
			startCount++;
		end
	end

	always @(posedge sda)
	begin
		if (active && scl === 1'b1)
		begin
			assert (st == sWaitStop) else reportText("STOP or SDA change before transfer end");
			st        = sIdle;
			slavePull = 1'b0;
		end
	end

	// Sampling on SCL rise
	always @(posedge scl)
	begin
		if (active)
		begin
			case (st)
				sAddr:
				begin
					shiftIn = {shiftIn[6:0], sda};
					bitCnt++;
					if (bitCnt == 8)
					begin
						assert (shiftIn == adrsOrder[orderIdx])
							else reportValue("address byte", adrsOrder[orderIdx], shiftIn);
						orderIdx = (orderIdx + 1) % 3;
						curAdrs  = shiftIn[7:1];
						st       = (curAdrs == nackAdrs) ? sWaitStop : sAckOut;
					end
				end
				sData:
				begin
					bitCnt++;
					if (bitCnt == 8)
						st = sByteEnd;
				end
				sHostAck:
				begin
					// ACK after byte one, NACK after the last
					assert (sda == (byteIdx != 0))
						else reportValue("host ACK bit", byteIdx != 0, sda);
					st = (byteIdx == 0) ? sNextByte : sWaitStop;
				end
				default: ;
			endcase
		end
	end

	// Driving on SCL fall
	always @(negedge scl)
	begin
		if (active)
		begin
			case (st)
				sAckOut:
				begin
					slavePull = 1'b1;	// Address ACK
					st        = sAckHold;
				end
				sAckHold, sNextByte:
				begin
					word      = pickData(curAdrs);
					byteIdx   = (st == sAckHold) ? 0 : 1;
					txByte    = (byteIdx == 0) ? word[15:8] : word[7:0];
					bitCnt    = 0;
					slavePull = ~txByte[7];
					st        = sData;
				end
				sData:     slavePull = ~txByte[7-bitCnt];
				sByteEnd:
				begin
					slavePull = 1'b0;	// Host owns the ACK bit
					st        = sHostAck;
				end
				default: ;
			endcase
		end
	end

endmodule

// File: bench/keyScanTb.sv
// Key scan host testbench
// Clock, reset, Wishbone access tasks, scan scenarios, SCL timing and watchdog
module keyScanTb;

	import i2cBusPkg::*;
	import keyScanPkg::*;

	// Three scans at the largest divider with margin
	localparam int watchdogCycles =
		3 * 3 * 30 * quartersPerBit * (int'(clkDivDefault) + 1) * 2 + 5000;

	logic        iSysClk;
	logic        rstN;
	logic        wbCyc;
	logic        wbStb;
	logic        wbWe;
	logic [2:0]  wbAdr;
	logic [15:0] wbDatW;
	logic [15:0] wbDatR;
	logic        wbAck;
	logic        sclOe;
	logic        sdaOe;
	logic        slavePull;
	logic        protoErr;
	logic [6:0]  nackAdrs;
	logic [15:0] modelData [0:2];	// Slave bytes per device
	logic [15:0] expData [0:2];		// Expected result registers
	logic [15:0] oldKey2;
	logic [15:0] status;
	int          startCount;
	int          startsBefore;
	int          seed;
	int          curDiv;
	int          highCnt;
	int          phaseCount;
	int          phasesBefore;
	logic        sdaMoved;
	logic        sclLast;
	logic        sdaLast;
	wire         scl;
	wire         sda;

	// Pulled-up open-drain lines
	assign scl = ~sclOe;
	assign sda = ~(sdaOe | slavePull);

	keyScanTop uut (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.wbCyc   (wbCyc),
		.wbStb   (wbStb),
		.wbWe    (wbWe),
		.wbAdr   (wbAdr),
		.wbDatW  (wbDatW),
		.sdaIn   (sda),
		.wbDatR  (wbDatR),
		.wbAck   (wbAck),
		.sclOe   (sclOe),
		.sdaOe   (sdaOe)
	);

	i2cSlaveModel uSlave (
		.scl        (scl),
		.sda        (sda),
		.active     (rstN),
		.nackAdrs   (nackAdrs),
		.keyData1   (modelData[0]),
		.keyData2   (modelData[1]),
		.gyroData   (modelData[2]),
		.slavePull  (slavePull),
		.startCount (startCount),
		.protoErr   (protoErr)
	);

	always #50 iSysClk = ~iSysClk;

	task automatic valueError(input string name, input logic [15:0] expVal,
		input logic [15:0] actVal);
		$display("[ERROR] %0t %s expected %0h actual %0h", $time, name, expVal, actVal);
		$display("SIMULATION FAILED");
		$fatal(1, "Value mismatch");
	endtask

	// Ack is a single-cycle pulse
	ackPulse: assert property (@(posedge iSysClk) disable iff (!rstN) wbAck |=> !wbAck)
		else valueError("wbAck", 16'h0, 16'h1);

	//----------------------------------------------------------------------
	// Wishbone classic accesses with ack one cycle after strobe
	//----------------------------------------------------------------------
	task automatic busAccess(input logic we, input logic [2:0] adr, input logic [15:0] dat,
		output logic [15:0] rdat);
		@(posedge iSysClk);
		wbCyc  <= 1'b1;
		wbStb  <= 1'b1;
		wbWe   <= we;
		wbAdr  <= adr;
		wbDatW <= dat;
		@(negedge iSysClk);
		assert (wbAck == 1'b0) else valueError("wbAck early", 16'h0, wbAck);
		@(negedge iSysClk);
		assert (wbAck == 1'b1) else valueError("wbAck", 16'h1, wbAck);
		rdat = wbDatR;
		@(posedge iSysClk);
		wbCyc <= 1'b0;
		wbStb <= 1'b0;
		wbWe  <= 1'b0;
	endtask

	task automatic writeReg(input logic [2:0] adr, input logic [15:0] dat);
		logic [15:0] unused;
		busAccess(1'b1, adr, dat, unused);
	endtask

	task automatic checkReg(input logic [2:0] adr, input string name, input logic [15:0] expVal);
		logic [15:0] dat;
		busAccess(1'b0, adr, 16'h0, dat);
		assert (dat == expVal) else valueError(name, expVal, dat);
	endtask

	task automatic newData();
		for (int i = 0; i < 3; i++)
		begin
			modelData[i] = $random(seed);
			expData[i]   = modelData[i];	// First byte lands in the upper half
		end
	endtask

	// Enable, see busy, poll for done
	task automatic scanOnce();
		writeReg(regCtrl, 16'h1);
		busAccess(1'b0, regStatus, 16'h0, status);
		assert (status[1] == 1'b1) else valueError("STATUS busy", 16'h1, status[1]);
		while (status[0] != 1'b1)
			busAccess(1'b0, regStatus, 16'h0, status);
	endtask

	task automatic checkResults();
		checkReg(regKeyPad1, "KEYPAD1", expData[0]);
		checkReg(regKeyPad2, "KEYPAD2", expData[1]);
		checkReg(regGyro, "GYRO", expData[2]);
	endtask

	//----------------------------------------------------------------------
	// SCL high phase length check, skipping phases with START or STOP
	//----------------------------------------------------------------------
	always @(negedge iSysClk)
	begin
		if (rstN)
		begin
			if (scl)
			begin
				if (sclLast && sda != sdaLast)
					sdaMoved = 1'b1;
				highCnt++;
			end
			else if (sclLast)
			begin
				if (!sdaMoved)
				begin
					assert (highCnt == 2 * (curDiv + 1))
						else valueError("SCL high cycles", 2 * (curDiv + 1), highCnt);
					phaseCount++;
				end
				highCnt  = 0;
				sdaMoved = 1'b0;
			end
			sclLast = scl;
			sdaLast = sda;
		end
	end

	// Model protocol failure
	initial
	begin
		wait (protoErr === 1'b1);
		$display("SIMULATION FAILED");
		$fatal(1, "I2C protocol check failed");
	end

	initial
	begin
		#(watchdogCycles * 100);
		$display("Watchdog expired, the scan never completed");
		$display("SIMULATION FAILED");
		$fatal(1, "Timeout");
	end

	initial
	begin
		seed       = 32'h82672941;
		iSysClk    = 1'b0;
		rstN       = 1'b0;
		wbCyc      = 1'b0;
		wbStb      = 1'b0;
		wbWe       = 1'b0;
		wbAdr      = '0;
		wbDatW     = '0;
		nackAdrs   = 7'h7f;	// Nobody ignored
		curDiv     = clkDivDefault;
		highCnt    = 0;
		phaseCount = 0;
		sdaMoved   = 1'b1;	// Skip the idle phase after reset
		sclLast    = 1'b1;
		sdaLast    = 1'b1;
		for (int i = 0; i < 3; i++)
		begin
			modelData[i] = '0;
			expData[i]   = '0;
		end
		repeat (8) @(posedge iSysClk);
		rstN <= 1'b1;

		// Reset state
		@(negedge iSysClk);
		assert (sclOe == 1'b0) else valueError("sclOe", 16'h0, sclOe);
		assert (sdaOe == 1'b0) else valueError("sdaOe", 16'h0, sdaOe);
		checkReg(regCtrl, "CTRL", 16'h0);
		checkReg(regStatus, "STATUS", 16'h0);
		checkReg(regClkDiv, "CLKDIV", clkDivDefault);
		checkResults();

		// Full scan
		newData();
		scanOnce();
		checkReg(regStatus, "STATUS", 16'h1);
		checkResults();

		// Done holds while enabled and no new START
		startsBefore = startCount;
		repeat (4) checkReg(regStatus, "STATUS", 16'h1);
		repeat (200) @(posedge iSysClk);
		assert (startCount == startsBefore)
			else valueError("START count", startsBefore, startCount);
		writeReg(regCtrl, 16'h0);
		checkReg(regStatus, "STATUS", 16'h0);
		newData();
		scanOnce();
		checkReg(regStatus, "STATUS", 16'h1);
		checkResults();
		writeReg(regCtrl, 16'h0);

		// Right keypad ignores its address
		oldKey2 = expData[1];
		newData();
		expData[1] = oldKey2;
		nackAdrs   = 7'h03;
		scanOnce();
		checkReg(regStatus, "STATUS", 16'h5);
		checkResults();
		writeReg(regCtrl, 16'h0);
		nackAdrs = 7'h7f;

		// Faster divider and error cleared by the new scan
		writeReg(regClkDiv, 16'd5);
		curDiv = 5;
		checkReg(regClkDiv, "CLKDIV", 16'd5);
		phasesBefore = phaseCount;
		newData();
		scanOnce();
		checkReg(regStatus, "STATUS", 16'h1);
		checkResults();
		assert (phaseCount > phasesBefore)
			else valueError("SCL phases measured", phasesBefore + 1, phaseCount);
		writeReg(regCtrl, 16'h0);

		if (protoErr)
		begin
			$display("SIMULATION FAILED");
			$fatal(1, "I2C protocol check failed");
		end
		else
		begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

// File: compile.f
verilog/i2cBusPkg.sv
verilog/keyScanPkg.sv
verilog/i2cClockGen.sv
verilog/i2cByteEngine.sv
verilog/keyScanSequencer.sv
verilog/keyScanRegs.sv
verilog/keyScanTop.sv
bench/i2cSlaveModel.sv
bench/keyScanTb.sv

// File: runSim.sh
#!/bin/sh
# Build the key scan testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module keyScanTb -f compile.f -o simKeyScan
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simKeyScan > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "SIMULATION PASSED" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: verilog/i2cBusPkg.sv
// I2C bus-level definitions
// Byte engine states, bit phase count, divider and length widths
package i2cBusPkg;

	//----------------------------------------------------------------------
	// Byte engine FSM
	//----------------------------------------------------------------------
	typedef enum logic [2:0] {
		IDLE     = 3'd0,	// Bus released, waiting for xferStart
		START    = 3'd1,	// SDA falls while SCL high
		ADDR     = 3'd2,	// 7-bit address + read bit, MSB first
		ADDR_ACK = 3'd3,	// Slave drives ACK
		DATA     = 3'd4,	// Slave drives 8 data bits
		DATA_ACK = 3'd5,	// Host drives ACK, NACK on last byte
		STOP     = 3'd6		// SDA rises while SCL high
	} engineState;

	//----------------------------------------------------------------------
	// Bit timing
	//----------------------------------------------------------------------
	localparam int quartersPerBit = 4;	// Ticks per SCL period, 2 low + 2 high

	// Divider register
	localparam int clkDivWidth = 16;
	localparam logic [clkDivWidth-1:0] clkDivDefault = 16'd24;	// 25 clocks per quarter

	// Transfer length counter
	localparam int byteCountWidth = 4;

endpackage

// File: verilog/i2cByteEngine.sv
// Bit-level I2C read engine
// START, address, data bytes with ACK/NACK, STOP, open-drain drive
module i2cByteEngine (
	input  logic                                  iSysClk,
	input  logic                                  rstN,
	input  logic                                  quarterTick,
	input  logic                                  xferStart,	// Ignored while busy
	input  logic [6:0]                            slaveAdrs,
	input  logic [i2cBusPkg::byteCountWidth-1:0]  xferLen,	// Bytes to read
	input  logic                                  sdaIn,
	output logic                                  sclOe,		// 1 pulls SCL low
	output logic                                  sdaOe,		// 1 pulls SDA low
	output logic                                  byteValid,
	output logic [7:0]                            rxByte,
	output logic                                  xferDone,
	output logic                                  addrNack,	// Valid with xferDone
	output logic                                  engineBusy
);

	import i2cBusPkg::*;

	localparam int quarterWidth = $clog2(quartersPerBit);
	// Quarter phases inside one bit, SCL low for q0 and q1
	localparam logic [quarterWidth-1:0] qDrive      = 0;	// Middle of low phase, SDA changes
	localparam logic [quarterWidth-1:0] qRelease    = 1;	// SCL goes high
	localparam logic [quarterWidth-1:0] qSample     = 2;	// Middle of high phase
	localparam logic [quarterWidth-1:0] lastQuarter = quarterWidth'(quartersPerBit - 1);

	engineState                state;
	logic [quarterWidth-1:0]   qCnt;
	logic [2:0]                bitCnt;		// Bit index, MSB first
	logic [7:0]                shiftReg;	// Address out, data in
	logic [byteCountWidth-1:0] bytesLeft;

	assign engineBusy = (state != IDLE);
	assign rxByte     = shiftReg;

	//----------------------------------------------------------------------
	// Shift register, address out and data in
	//----------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (state == IDLE && xferStart)
		begin
			shiftReg <= {slaveAdrs, 1'b1};	// Read bit set
		end
		else if (quarterTick && state == ADDR && qCnt == lastQuarter)
		begin
			shiftReg <= {shiftReg[6:0], 1'b0};
		end
		else if (quarterTick && state == DATA && qCnt == qSample)
		begin
			shiftReg <= {shiftReg[6:0], sdaIn};
		end
	end

	//----------------------------------------------------------------------
	// Engine FSM, advances on quarter ticks
	//----------------------------------------------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			state     <= IDLE;
			qCnt      <= '0;
			bitCnt    <= '0;
			bytesLeft <= '0;
			sclOe     <= 1'b0;
			sdaOe     <= 1'b0;
			byteValid <= 1'b0;
			xferDone  <= 1'b0;
			addrNack  <= 1'b0;
		end
		else
		begin
			byteValid <= 1'b0;	// Pulses
			xferDone  <= 1'b0;
			if (state == IDLE)
			begin
				qCnt <= '0;
				if (xferStart)
				begin
					state     <= START;
					bytesLeft <= xferLen;
					addrNack  <= 1'b0;
				end
			end
			else if (quarterTick)
			begin
				qCnt <= qCnt + 1'b1;	// Wraps at end of bit
				case (state)
					START:
					begin
						if (qCnt == qDrive)
							sdaOe <= 1'b1;	// SDA falls, SCL still high
						if (qCnt == qRelease)
						begin
							sclOe  <= 1'b1;
							qCnt   <= '0;
							bitCnt <= 3'd7;
							state  <= ADDR;
						end
					end
					ADDR:
					begin
						if (qCnt == qDrive)
							sdaOe <= ~shiftReg[7];
						if (qCnt == qRelease)
							sclOe <= 1'b0;
						if (qCnt == lastQuarter)
						begin
							sclOe <= 1'b1;
							if (bitCnt == 3'd0)
								state <= ADDR_ACK;
							else
								bitCnt <= bitCnt - 1'b1;
						end
					end
					ADDR_ACK:
					begin
						if (qCnt == qDrive)
							sdaOe <= 1'b0;	// Let slave drive
						if (qCnt == qRelease)
							sclOe <= 1'b0;
						if (qCnt == qSample)
							addrNack <= sdaIn;	// High means no slave
						if (qCnt == lastQuarter)
						begin
							sclOe  <= 1'b1;
							bitCnt <= 3'd7;
							state  <= addrNack ? STOP : DATA;
						end
					end
					DATA:
					begin
						if (qCnt == qDrive)
							sdaOe <= 1'b0;
						if (qCnt == qRelease)
							sclOe <= 1'b0;
						if (qCnt == lastQuarter)
						begin
							sclOe <= 1'b1;
							if (bitCnt == 3'd0)
							begin
								byteValid <= 1'b1;	// Full byte in shiftReg
								bytesLeft <= bytesLeft - 1'b1;
								state     <= DATA_ACK;
							end
							else
							begin
								bitCnt <= bitCnt - 1'b1;
							end
						end
					end
					DATA_ACK:
					begin
						if (qCnt == qDrive)
							sdaOe <= (bytesLeft != '0);	// ACK, NACK on last byte
						if (qCnt == qRelease)
							sclOe <= 1'b0;
						if (qCnt == lastQuarter)
						begin
							sclOe  <= 1'b1;
							bitCnt <= 3'd7;
							state  <= (bytesLeft == '0) ? STOP : DATA;
						end
					end
					STOP:
					begin
						if (qCnt == qDrive)
							sdaOe <= 1'b1;	// SDA low under SCL low
						if (qCnt == qRelease)
							sclOe <= 1'b0;
						if (qCnt == lastQuarter)
						begin
							sdaOe    <= 1'b0;	// SDA rises, SCL high
							xferDone <= 1'b1;
							state    <= IDLE;
						end
					end
					default: state <= IDLE;
				endcase
			end
		end
	end

endmodule

// File: verilog/i2cClockGen.sv
// Quarter-bit tick generator for the I2C byte engine
module i2cClockGen (
	input  logic                               iSysClk,
	input  logic                               rstN,
	input  logic                               run,		// Engine busy
	input  logic [i2cBusPkg::clkDivWidth-1:0]  clkDiv,	// Quarter period minus one
	output logic                               quarterTick
);

	import i2cBusPkg::*;

	logic [clkDivWidth-1:0] divCnt;	// Counts down to zero

	//----------------------------------------------------------------------
	// Down-counter, preloaded while idle
	//----------------------------------------------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			divCnt <= '0;
		end
		else if (!run)
		begin
			divCnt <= clkDiv;	// Full period before first tick
		end
		else if (divCnt == '0)
		begin
			divCnt <= clkDiv;	// Reload on tick
		end
		else
		begin
			divCnt <= divCnt - 1'b1;
		end
	end

	// One pulse every clkDiv+1 clocks while running
	assign quarterTick = run && (divCnt == '0);

endmodule

// File: verilog/keyScanPkg.sv
// Scan-level definitions
// Device select FSM, slave addresses, register map and bus width
package keyScanPkg;

	//----------------------------------------------------------------------
	// Scan sequencer states
	//----------------------------------------------------------------------
	typedef enum logic [2:0] {
		STOP = 3'd0,	// Waiting for enable
		KEY1 = 3'd1,	// Left keypad transfer
		KEY2 = 3'd2,	// Right keypad transfer
		GYRO = 3'd3,	// Gyro sensor transfer
		COMP = 3'd4		// Scan done, hold until enable drops
	} deviceSel;

	// 7-bit slave addresses
	localparam logic [6:0] keyPadAdrs1 = 7'h02;	// Left keypad
	localparam logic [6:0] keyPadAdrs2 = 7'h03;	// Right keypad
	localparam logic [6:0] gyroAdrs    = 7'h04;	// Gyro sensor

	localparam logic [i2cBusPkg::byteCountWidth-1:0] bytesPerDevice = 2;

	//----------------------------------------------------------------------
	// Register map, word addresses
	//----------------------------------------------------------------------
	localparam int regAdrsWidth = 3;
	localparam logic [regAdrsWidth-1:0] regCtrl    = 3'd0;	// Bit 0 enable
	localparam logic [regAdrsWidth-1:0] regStatus  = 3'd1;	// Done, busy, NACK error
	localparam logic [regAdrsWidth-1:0] regClkDiv  = 3'd2;
	localparam logic [regAdrsWidth-1:0] regKeyPad1 = 3'd3;
	localparam logic [regAdrsWidth-1:0] regKeyPad2 = 3'd4;
	localparam logic [regAdrsWidth-1:0] regGyro    = 3'd5;

	localparam int dataWidth = 16;	// Wishbone data bus

endpackage

// File: verilog/keyScanRegs.sv
// Wishbone classic register block
// Control, status, divider and the three scan result registers
module keyScanRegs (
	input  logic                                 iSysClk,
	input  logic                                 rstN,
	input  logic                                 wbCyc,
	input  logic                                 wbStb,
	input  logic                                 wbWe,
	input  logic [keyScanPkg::regAdrsWidth-1:0]  wbAdr,
	input  logic [keyScanPkg::dataWidth-1:0]     wbDatW,
	input  logic                                 capWe,
	input  keyScanPkg::deviceSel                 capDev,
	input  logic [7:0]                           capByte,
	input  logic                                 seqDone,
	input  logic                                 seqBusy,
	input  logic                                 nackErr,
	output logic [keyScanPkg::dataWidth-1:0]     wbDatR,
	output logic                                 wbAck,
	output logic                                 scanEn,
	output logic [i2cBusPkg::clkDivWidth-1:0]    clkDiv
);

	import i2cBusPkg::*;
	import keyScanPkg::*;

	logic                 busHit;		// Access accepted this cycle
	logic [dataWidth-1:0] keyPad1;
	logic [dataWidth-1:0] keyPad2;
	logic [dataWidth-1:0] gyroData;
	logic [dataWidth-1:0] readMux;

	assign busHit = wbCyc && wbStb && !wbAck;

	// Read select, unused addresses give zero
	always_comb
	begin
		readMux = '0;
		case (wbAdr)
			regCtrl:    readMux[0]   = scanEn;
			regStatus:  readMux[2:0] = {nackErr, seqBusy, seqDone};
			regClkDiv:  readMux      = clkDiv;
			regKeyPad1: readMux      = keyPad1;
			regKeyPad2: readMux      = keyPad2;
			regGyro:    readMux      = gyroData;
			default:    readMux      = '0;
		endcase
	end

	//----------------------------------------------------------------------
	// Bus side, single-cycle registered ack
	//----------------------------------------------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			wbAck  <= 1'b0;
			wbDatR <= '0;
			scanEn <= 1'b0;
			clkDiv <= clkDivDefault;
		end
		else
		begin
			wbAck <= busHit;
			if (busHit)
				wbDatR <= readMux;	// Valid with wbAck
			if (busHit && wbWe)
			begin
				if (wbAdr == regCtrl)
					scanEn <= wbDatW[0];
				if (wbAdr == regClkDiv)
					clkDiv <= wbDatW;
			end
		end
	end

	//----------------------------------------------------------------------
	// Result capture, new byte into low half
	//----------------------------------------------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			keyPad1  <= '0;
			keyPad2  <= '0;
			gyroData <= '0;
		end
		else if (capWe)
		begin
			case (capDev)
				KEY1:    keyPad1  <= {keyPad1[dataWidth-9:0], capByte};
				KEY2:    keyPad2  <= {keyPad2[dataWidth-9:0], capByte};
				GYRO:    gyroData <= {gyroData[dataWidth-9:0], capByte};
				default: keyPad1  <= keyPad1;	// No capture outside a transfer
			endcase
		end
	end

endmodule

// File: verilog/keyScanSequencer.sv
// Scan sequencer FSM
// Walks keypads and gyro, starts transfers, routes bytes, tracks done and error
module keyScanSequencer (
	input  logic                                  iSysClk,
	input  logic                                  rstN,
	input  logic                                  scanEn,		// CTRL enable
	input  logic                                  byteValid,
	input  logic [7:0]                            rxByte,
	input  logic                                  xferDone,
	input  logic                                  addrNack,
	output logic                                  xferStart,	// One-cycle pulse
	output logic [6:0]                            slaveAdrs,
	output logic [i2cBusPkg::byteCountWidth-1:0]  xferLen,
	output logic                                  capWe,
	output keyScanPkg::deviceSel                  capDev,
	output logic [7:0]                            capByte,
	output logic                                  seqDone,
	output logic                                  seqBusy,
	output logic                                  nackErr
);

	import keyScanPkg::*;

	deviceSel devSel;	// Current device
	deviceSel devNext;

	assign xferLen = bytesPerDevice;	// Same length for every device
	assign seqDone = (devSel == COMP);
	assign seqBusy = (devSel == KEY1) || (devSel == KEY2) || (devSel == GYRO);

	//----------------------------------------------------------------------
	// Next device
	//----------------------------------------------------------------------
	always_comb
	begin
		devNext = devSel;
		case (devSel)
			STOP:    if (scanEn) devNext = KEY1;
			KEY1:    if (xferDone) devNext = KEY2;
			KEY2:    if (xferDone) devNext = GYRO;
			GYRO:    if (xferDone) devNext = COMP;
			COMP:    if (!scanEn) devNext = STOP;	// Hold until enable drops
			default: devNext = STOP;
		endcase
	end

	//----------------------------------------------------------------------
	// State, transfer start and error flag
	//----------------------------------------------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			devSel    <= STOP;
			xferStart <= 1'b0;
			slaveAdrs <= '0;
			nackErr   <= 1'b0;
			capWe     <= 1'b0;
			capDev    <= STOP;
		end
		else
		begin
			devSel    <= devNext;
			xferStart <= 1'b0;
			// Kick the engine on entry to a device state
			if (devNext != devSel)
			begin
				case (devNext)
					KEY1:
					begin
						xferStart <= 1'b1;
						slaveAdrs <= keyPadAdrs1;
					end
					KEY2:
					begin
						xferStart <= 1'b1;
						slaveAdrs <= keyPadAdrs2;
					end
					GYRO:
					begin
						xferStart <= 1'b1;
						slaveAdrs <= gyroAdrs;
					end
					default: xferStart <= 1'b0;
				endcase
			end

			if (devSel == STOP && devNext == KEY1)
				nackErr <= 1'b0;	// New scan
			else if (xferDone && addrNack)
				nackErr <= 1'b1;	// Sticky for this scan

			capWe  <= byteValid;	// Byte strobe to result regs
			capDev <= devSel;		// Tag with current device
		end
	end

	// Received byte, follows byteValid by one cycle with capWe
	always_ff @(posedge iSysClk)
	begin
		if (byteValid)
			capByte <= rxByte;
	end

endmodule

// File: verilog/keyScanTop.sv
// Key scan I2C host top level
// Registers, sequencer, clock generator and byte engine
module keyScanTop (
	input  logic                                 iSysClk,
	input  logic                                 rstN,
	input  logic                                 wbCyc,
	input  logic                                 wbStb,
	input  logic                                 wbWe,
	input  logic [keyScanPkg::regAdrsWidth-1:0]  wbAdr,
	input  logic [keyScanPkg::dataWidth-1:0]     wbDatW,
	input  logic                                 sdaIn,
	output logic [keyScanPkg::dataWidth-1:0]     wbDatR,
	output logic                                 wbAck,
	output logic                                 sclOe,
	output logic                                 sdaOe
);

	import i2cBusPkg::*;
	import keyScanPkg::*;

	// Registers to sequencer and divider
	logic                   scanEn;
	logic [clkDivWidth-1:0] clkDiv;
	// Sequencer to registers
	logic                   capWe;
	deviceSel               capDev;
	logic [7:0]             capByte;
	logic                   seqDone;
	logic                   seqBusy;
	logic                   nackErr;
	// Sequencer and byte engine handshake
	logic                      xferStart;
	logic [6:0]                slaveAdrs;
	logic [byteCountWidth-1:0] xferLen;
	logic                      byteValid;
	logic [7:0]                rxByte;
	logic                      xferDone;
	logic                      addrNack;
	logic                      engineBusy;
	logic                      quarterTick;

	keyScanRegs uRegs (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.wbCyc   (wbCyc),
		.wbStb   (wbStb),
		.wbWe    (wbWe),
		.wbAdr   (wbAdr),
		.wbDatW  (wbDatW),
		.capWe   (capWe),
		.capDev  (capDev),
		.capByte (capByte),
		.seqDone (seqDone),
		.seqBusy (seqBusy),
		.nackErr (nackErr),
		.wbDatR  (wbDatR),
		.wbAck   (wbAck),
		.scanEn  (scanEn),
		.clkDiv  (clkDiv)
	);

	keyScanSequencer uSequencer (
		.iSysClk   (iSysClk),
		.rstN      (rstN),
		.scanEn    (scanEn),
		.byteValid (byteValid),
		.rxByte    (rxByte),
		.xferDone  (xferDone),
		.addrNack  (addrNack),
		.xferStart (xferStart),
		.slaveAdrs (slaveAdrs),
		.xferLen   (xferLen),
		.capWe     (capWe),
		.capDev    (capDev),
		.capByte   (capByte),
		.seqDone   (seqDone),
		.seqBusy   (seqBusy),
		.nackErr   (nackErr)
	);

	// Divider runs only during a transfer
	i2cClockGen uClockGen (
		.iSysClk     (iSysClk),
		.rstN        (rstN),
		.run         (engineBusy),
		.clkDiv      (clkDiv),
		.quarterTick (quarterTick)
	);

	i2cByteEngine uByteEngine (
		.iSysClk     (iSysClk),
		.rstN        (rstN),
		.quarterTick (quarterTick),
		.xferStart   (xferStart),
		.slaveAdrs   (slaveAdrs),
		.xferLen     (xferLen),
		.sdaIn       (sdaIn),
		.sclOe       (sclOe),
		.sdaOe       (sdaOe),
		.byteValid   (byteValid),
		.rxByte      (rxByte),
		.xferDone    (xferDone),
		.addrNack    (addrNack),
		.engineBusy  (engineBusy)
	);

endmodule
